/* Bender.yml */
package:
  name: axi_router

sources:
  - rtl/axi_router_cfg_pkg.sv
  - rtl/axi_router_types_pkg.sv
  - rtl/req_steer.sv
  - rtl/slave_port.sv
  - rtl/resp_merger.sv
  - rtl/axi_router_top.sv
  - target: simulation
    files:
      - sim/tb_slave_model.sv
      - sim/tb_axi_router.sv

/* files.f */
rtl/axi_router_cfg_pkg.sv
rtl/axi_router_types_pkg.sv
rtl/req_steer.sv
rtl/slave_port.sv
rtl/resp_merger.sv
rtl/axi_router_top.sv
sim/tb_slave_model.sv
sim/tb_axi_router.sv

/* rtl/axi_router_cfg_pkg.sv */
// AXI router configuration
// address map, bus widths, slave count and the credit and queue
// depths shared by the write and read paths
`default_nettype none

package axi_router_cfg_pkg;

    // ========================================
    // slave ports
    // ========================================
    localparam int NUM_SLAVES = 3;
    localparam int SLV_IDX_W  = $clog2(NUM_SLAVES);

    // ========================================
    // bus widths
    // ========================================
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int ID_W   = 4;
    localparam int STRB_W = DATA_W / 8;
    localparam int RESP_W = 2;

    // ========================================
    // address map
    // ========================================
    localparam int REGION_MSB = 31;
    localparam int REGION_LSB = 24;
    localparam int REGION_W   = REGION_MSB - REGION_LSB + 1;

    localparam logic [REGION_W-1:0] IO_REGION    = 8'h10;
    localparam logic [REGION_W-1:0] TIMER_REGION = 8'h02;

    // IO / TIME / ELSE numbering
    localparam int IO_SLAVE      = 0;
    localparam int TIMER_SLAVE   = 1;
    localparam int DEFAULT_SLAVE = 2;

    // ========================================
    // flow control, depths are powers of two
    // ========================================
    localparam int REQ_CREDITS = 2;
    localparam int RESP_DEPTH  = 2;
    localparam int ORDER_DEPTH = 8;

endpackage

`default_nettype wire

/* rtl/axi_router_top.sv */
// AXI router top
// one master, three slaves (IO, timer, default), separate write and
// read paths, valid/ready to the master and credits to the slaves
`default_nettype none

module axi_router_top (
    input  logic                                  clk,
    input  logic                                  rst_n,

    // master write path
    input  logic                                  wr_valid,
    input  axi_router_types_pkg::wr_req_t         wr_req,
    output logic                                  wr_ready,
    output logic                                  b_valid,
    output axi_router_types_pkg::b_resp_t         b_resp,
    input  logic                                  b_ready,

    // master read path
    input  logic                                  rd_valid,
    input  axi_router_types_pkg::rd_req_t         rd_req,
    output logic                                  rd_ready,
    output logic                                  r_valid,
    output axi_router_types_pkg::r_resp_t         r_resp,
    input  logic                                  r_ready,

    // slave write path
    output logic [axi_router_cfg_pkg::NUM_SLAVES-1:0] aw_valid,
    output axi_router_types_pkg::wr_req_t [axi_router_cfg_pkg::NUM_SLAVES-1:0] aw_req,
    input  logic [axi_router_cfg_pkg::NUM_SLAVES-1:0] aw_credit,
    input  logic [axi_router_cfg_pkg::NUM_SLAVES-1:0] bs_valid,
    input  axi_router_types_pkg::b_resp_t [axi_router_cfg_pkg::NUM_SLAVES-1:0] bs_resp,
    output logic [axi_router_cfg_pkg::NUM_SLAVES-1:0] bs_credit,

    // slave read path
    output logic [axi_router_cfg_pkg::NUM_SLAVES-1:0] ar_valid,
    output axi_router_types_pkg::rd_req_t [axi_router_cfg_pkg::NUM_SLAVES-1:0] ar_req,
    input  logic [axi_router_cfg_pkg::NUM_SLAVES-1:0] ar_credit,
    input  logic [axi_router_cfg_pkg::NUM_SLAVES-1:0] rs_valid,
    input  axi_router_types_pkg::r_resp_t [axi_router_cfg_pkg::NUM_SLAVES-1:0] rs_resp,
    output logic [axi_router_cfg_pkg::NUM_SLAVES-1:0] rs_credit
);

    import axi_router_cfg_pkg::*;
    import axi_router_types_pkg::*;

    logic [NUM_SLAVES-1:0] wr_port_load;
    logic [NUM_SLAVES-1:0] wr_port_ready;
    logic                  wr_order_push;
    slave_idx_t            wr_order_idx;
    logic                  wr_order_ready;

    logic [NUM_SLAVES-1:0] rd_port_load;
    logic [NUM_SLAVES-1:0] rd_port_ready;
    logic                  rd_order_push;
    slave_idx_t            rd_order_idx;
    logic                  rd_order_ready;

    // ========================================
    // write path
    // ========================================
    req_steer #(.payload_t(wr_req_t)) u_wr_steer (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (wr_valid),
        .req         (wr_req),
        .req_ready   (wr_ready),
        .port_load   (wr_port_load),
        .port_ready  (wr_port_ready),
        .order_push  (wr_order_push),
        .order_idx   (wr_order_idx),
        .order_ready (wr_order_ready)
    );

    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_wr_port
        slave_port #(.payload_t(wr_req_t)) u_port (
            .clk        (clk),
            .rst_n      (rst_n),
            .load       (wr_port_load[i]),
            .load_data  (wr_req),
            .ready      (wr_port_ready[i]),
            .slv_valid  (aw_valid[i]),
            .slv_req    (aw_req[i]),
            .slv_credit (aw_credit[i])
        );
    end

    resp_merger #(.payload_t(b_resp_t)) u_b_merge (
        .clk         (clk),
        .rst_n       (rst_n),
        .order_push  (wr_order_push),
        .order_idx   (wr_order_idx),
        .order_ready (wr_order_ready),
        .slv_valid   (bs_valid),
        .slv_resp    (bs_resp),
        .slv_credit  (bs_credit),
        .mst_valid   (b_valid),
        .mst_resp    (b_resp),
        .mst_ready   (b_ready)
    );

    // ========================================
    // read path
    // ========================================
    req_steer #(.payload_t(rd_req_t)) u_rd_steer (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (rd_valid),
        .req         (rd_req),
        .req_ready   (rd_ready),
        .port_load   (rd_port_load),
        .port_ready  (rd_port_ready),
        .order_push  (rd_order_push),
        .order_idx   (rd_order_idx),
        .order_ready (rd_order_ready)
    );

    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_rd_port
        slave_port #(.payload_t(rd_req_t)) u_port (
            .clk        (clk),
            .rst_n      (rst_n),
            .load       (rd_port_load[i]),
            .load_data  (rd_req),
            .ready      (rd_port_ready[i]),
            .slv_valid  (ar_valid[i]),
            .slv_req    (ar_req[i]),
            .slv_credit (ar_credit[i])
        );
    end

    resp_merger #(.payload_t(r_resp_t)) u_r_merge (
        .clk         (clk),
        .rst_n       (rst_n),
        .order_push  (rd_order_push),
        .order_idx   (rd_order_idx),
        .order_ready (rd_order_ready),
        .slv_valid   (rs_valid),
        .slv_resp    (rs_resp),
        .slv_credit  (rs_credit),
        .mst_valid   (r_valid),
        .mst_resp    (r_resp),
        .mst_ready   (r_ready)
    );

endmodule

`default_nettype wire

/* rtl/axi_router_types_pkg.sv */
// AXI router payload types
// packed request and response payloads for both paths and the
// slave index used by the order queues
`default_nettype none

package axi_router_types_pkg;

    import axi_router_cfg_pkg::*;

    typedef logic [SLV_IDX_W-1:0] slave_idx_t;

    // ========================================
    // requests, address always in the top bits
    // ========================================
    // req_steer finds the region there for any request type
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic [ID_W-1:0]   id;
    } wr_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
    } rd_req_t;

    // ========================================
    // responses
    // ========================================
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [RESP_W-1:0] resp;
    } b_resp_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [RESP_W-1:0] resp;
    } r_resp_t;

endpackage

`default_nettype wire

/* rtl/req_steer.sv */
// request steering
// decodes the region of the request address, loads the chosen
// slave port and logs the slave index for in-order responses
`default_nettype none

module req_steer #(
    parameter type payload_t = logic [axi_router_cfg_pkg::ADDR_W-1:0]
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  req_valid,
    input  payload_t                              req,
    output logic                                  req_ready,
    output logic [axi_router_cfg_pkg::NUM_SLAVES-1:0] port_load,
    input  logic [axi_router_cfg_pkg::NUM_SLAVES-1:0] port_ready,
    output logic                                  order_push,
    output axi_router_types_pkg::slave_idx_t      order_idx,
    input  logic                                  order_ready
);

    import axi_router_cfg_pkg::*;
    import axi_router_types_pkg::*;

    localparam int ADDR_LSB = $bits(payload_t) - ADDR_W;

    logic [REGION_W-1:0] region;
    slave_idx_t          tgt_idx;
    logic                accept;

    assign region = req[ADDR_LSB + REGION_MSB : ADDR_LSB + REGION_LSB];

    // region decode
    always_comb begin
        case (region)
            IO_REGION:    tgt_idx = slave_idx_t'(IO_SLAVE);
            TIMER_REGION: tgt_idx = slave_idx_t'(TIMER_SLAVE);
            default:      tgt_idx = slave_idx_t'(DEFAULT_SLAVE);
        endcase
    end

    // only the decoded port matters for ready
    assign req_ready = port_ready[tgt_idx] && order_ready;
    assign accept    = req_valid && req_ready;

    always_comb begin
        port_load          = '0;
        port_load[tgt_idx] = accept;
    end

    // order entry written on the accept edge
    assign order_push = accept;
    assign order_idx  = tgt_idx;

    // ========================================
    // checks
    // ========================================
    a_load_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(port_load))
        else $error("port load not one-hot");

    // a stalled master request must keep its target
    a_stall_target: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> tgt_idx == $past(tgt_idx))
        else $error("target slave changed while request was stalled");

endmodule

`default_nettype wire

/* rtl/resp_merger.sv */
// response merger
// buffers responses per slave, keeps the order of accepted requests
// and returns responses to the master in that order, handing one
// response credit back to the slave on every pop
`default_nettype none

module resp_merger #(
    parameter type payload_t = logic [axi_router_cfg_pkg::DATA_W-1:0]
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      order_push,
    input  axi_router_types_pkg::slave_idx_t          order_idx,
    output logic                                      order_ready,
    input  logic     [axi_router_cfg_pkg::NUM_SLAVES-1:0] slv_valid,
    input  payload_t [axi_router_cfg_pkg::NUM_SLAVES-1:0] slv_resp,
    output logic     [axi_router_cfg_pkg::NUM_SLAVES-1:0] slv_credit,
    output logic                                      mst_valid,
    output payload_t                                  mst_resp,
    input  logic                                      mst_ready
);

    import axi_router_cfg_pkg::*;
    import axi_router_types_pkg::*;

    localparam int OPTR_W = $clog2(ORDER_DEPTH);
    localparam int OCNT_W = $clog2(ORDER_DEPTH + 1);
    localparam int RPTR_W = $clog2(RESP_DEPTH);
    localparam int RCNT_W = $clog2(RESP_DEPTH + 1);

    slave_idx_t        ord_mem [ORDER_DEPTH];
    logic [OPTR_W-1:0] ord_wr;
    logic [OPTR_W-1:0] ord_rd;
    logic [OCNT_W-1:0] ord_cnt;
    logic [OCNT_W-1:0] ord_cnt_next;
    slave_idx_t        head_idx;

    payload_t          resp_mem [NUM_SLAVES][RESP_DEPTH];
    logic [RPTR_W-1:0] resp_wr  [NUM_SLAVES];
    logic [RPTR_W-1:0] resp_rd  [NUM_SLAVES];
    logic [RCNT_W-1:0] resp_cnt [NUM_SLAVES];

    logic                  pop;
    logic [NUM_SLAVES-1:0] pop_vec;

    // ========================================
    // head selection
    // ========================================
    assign head_idx  = ord_mem[ord_rd];
    assign mst_valid = (ord_cnt != '0) && (resp_cnt[head_idx] != '0);
    assign mst_resp  = resp_mem[head_idx][resp_rd[head_idx]];
    assign pop       = mst_valid && mst_ready;

    always_comb begin
        pop_vec           = '0;
        pop_vec[head_idx] = pop;
    end

    // ========================================
    // order queue
    // ========================================
    assign ord_cnt_next = ord_cnt + OCNT_W'(order_push) - OCNT_W'(pop);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ord_wr      <= '0;
            ord_rd      <= '0;
            ord_cnt     <= '0;
            order_ready <= 1'b0;
            slv_credit  <= '0;
        end else begin
            if (order_push) begin
                ord_wr <= ord_wr + 1'b1;
            end
            if (pop) begin
                ord_rd <= ord_rd + 1'b1;
            end
            ord_cnt     <= ord_cnt_next;
            // registered not-full, low through reset
            order_ready <= (ord_cnt_next != OCNT_W'(ORDER_DEPTH));
            slv_credit  <= pop_vec;
        end
    end

    always_ff @(posedge clk) begin
        if (order_push) begin
            ord_mem[ord_wr] <= order_idx;
        end
    end

    a_order_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        order_push |-> ord_cnt != OCNT_W'(ORDER_DEPTH))
        else $error("order queue pushed while full");

    // ========================================
    // per-slave response queues
    // ========================================
    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_resp_q
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                resp_wr[i]  <= '0;
                resp_rd[i]  <= '0;
                resp_cnt[i] <= '0;
            end else begin
                if (slv_valid[i]) begin
                    resp_wr[i] <= resp_wr[i] + 1'b1;
                end
                if (pop_vec[i]) begin
                    resp_rd[i] <= resp_rd[i] + 1'b1;
                end
                resp_cnt[i] <= resp_cnt[i] + RCNT_W'(slv_valid[i]) - RCNT_W'(pop_vec[i]);
            end
        end

        always_ff @(posedge clk) begin
            if (slv_valid[i]) begin
                resp_mem[i][resp_wr[i]] <= slv_resp[i];
            end
        end

        // slave must hold a response credit
        a_no_full_write: assert property (@(posedge clk) disable iff (!rst_n)
            slv_valid[i] |-> resp_cnt[i] != RCNT_W'(RESP_DEPTH))
            else $error("slave %0d wrote a full response queue", i);

        // responses only exist for logged requests, so pops never see an empty order queue
        a_resp_ordered: assert property (@(posedge clk) disable iff (!rst_n)
            resp_cnt[i] != '0 |-> ord_cnt != '0)
            else $error("slave %0d response without outstanding request", i);
    end

endmodule

`default_nettype wire

/* rtl/slave_port.sv */
// slave port stage
// one-entry request holding stage towards a slave, issuing each
// held request as a single-cycle pulse against request credits
`default_nettype none

module slave_port #(
    parameter type payload_t = logic [axi_router_cfg_pkg::ADDR_W-1:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  payload_t load_data,
    output logic     ready,
    output logic     slv_valid,
    output payload_t slv_req,
    input  logic     slv_credit
);

    import axi_router_cfg_pkg::*;

    localparam int CNT_W = $clog2(REQ_CREDITS + 1);

    logic             full;
    logic [CNT_W-1:0] credits;
    payload_t         hold_q;

    // issue whenever something is held and a credit is left
    assign slv_valid = full && (credits != '0);
    assign slv_req   = hold_q;

    // a slot frees in the issuing cycle
    assign ready = !full || slv_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full    <= 1'b0;
            credits <= CNT_W'(REQ_CREDITS);
        end else begin
            if (load) begin
                full <= 1'b1;
            end else if (slv_valid) begin
                full <= 1'b0;
            end
            credits <= credits - CNT_W'(slv_valid) + CNT_W'(slv_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            hold_q <= load_data;
        end
    end

    // ========================================
    // checks
    // ========================================
    // after the last credit is spent nothing goes out until one returns
    a_no_issue_at_zero: assert property (@(posedge clk) disable iff (!rst_n)
        slv_valid && credits == CNT_W'(1) && !slv_credit |=> !slv_valid)
        else $error("request issued with no credit left");

    // the slave must not return more credits than it granted
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CNT_W'(REQ_CREDITS))
        else $error("request credit count above limit");

    a_load_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> ready)
        else $error("port loaded while full");

endmodule

`default_nettype wire

/* sim/tb_axi_router.sv */
// AXI router testbench
// random writes and reads to all three regions, random master
// back-pressure, in-order checks against a reference model
`default_nettype none

module tb_axi_router;

    import axi_router_cfg_pkg::*;
    import axi_router_types_pkg::*;

    localparam int NUM_WR = 200;
    localparam int NUM_RD = 200;
    localparam int LIMIT  = 20 * (NUM_WR + NUM_RD) + 20;

    logic clk;
    logic rst_n;
    logic wr_valid;
    wr_req_t wr_req;
    logic wr_ready;
    logic b_valid;
    b_resp_t b_resp;
    logic b_ready;
    logic rd_valid;
    rd_req_t rd_req;
    logic rd_ready;
    logic r_valid;
    r_resp_t r_resp;
    logic r_ready;

    logic [NUM_SLAVES-1:0] aw_valid;
    wr_req_t [NUM_SLAVES-1:0] aw_req;
    logic [NUM_SLAVES-1:0] aw_credit;
    logic [NUM_SLAVES-1:0] bs_valid;
    b_resp_t [NUM_SLAVES-1:0] bs_resp;
    logic [NUM_SLAVES-1:0] bs_credit;
    logic [NUM_SLAVES-1:0] ar_valid;
    rd_req_t [NUM_SLAVES-1:0] ar_req;
    logic [NUM_SLAVES-1:0] ar_credit;
    logic [NUM_SLAVES-1:0] rs_valid;
    r_resp_t [NUM_SLAVES-1:0] rs_resp;
    logic [NUM_SLAVES-1:0] rs_credit;

    int wr_slv_err [NUM_SLAVES];
    int rd_slv_err [NUM_SLAVES];
    int wr_errs;
    int rd_errs;
    int other_errs;
    int cycles;
    logic post_rst;
    logic [31:0] wr_st;
    logic [31:0] rd_st;
    logic [31:0] rdy_st;

    wr_req_t exp_aw [NUM_SLAVES][$];
    rd_req_t exp_ar [NUM_SLAVES][$];
    b_resp_t exp_b [$];
    r_resp_t exp_r [$];

    axi_router_top UUT (.*);

    // ========================================
    // reference model
    // ========================================
    function automatic logic [63:0] signature(input int idx);
        case (idx)
            0:       return 64'h0123_4567_89ab_cdef;
            1:       return 64'hfeed_5a5a_c3c3_0f0f;
            default: return 64'h0;
        endcase
    endfunction

    function automatic slave_idx_t route(input logic [ADDR_W-1:0] addr);
        case (addr[REGION_MSB:REGION_LSB])
            IO_REGION:    return slave_idx_t'(IO_SLAVE);
            TIMER_REGION: return slave_idx_t'(TIMER_SLAVE);
            default:      return slave_idx_t'(DEFAULT_SLAVE);
        endcase
    endfunction

    function automatic r_resp_t expected_read(input rd_req_t req);
        r_resp_t    r;
        slave_idx_t idx;
        idx    = route(req.addr);
        r.id   = req.id;
        r.resp = (idx == DEFAULT_SLAVE) ? 2'b11 : 2'b00;
        r.data = (idx == DEFAULT_SLAVE) ? 64'h0 : ({32'h0, req.addr} ^ signature(idx));
        return r;
    endfunction

    function automatic b_resp_t expected_write(input wr_req_t req);
        b_resp_t b;
        b.id   = req.id;
        b.resp = (route(req.addr) == DEFAULT_SLAVE) ? 2'b11 : 2'b00;
        return b;
    endfunction

    // fibonacci LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            st = {st[30:0], st[31] ^ st[21] ^ st[1] ^ st[0]};
            v  = {v[30:0], st[0]};
        end
        return v;
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(inout logic [31:0] st);
        logic [7:0]  region;
        logic [23:0] offset;
        case (take_bits(st, 2))
            0:       region = IO_REGION;
            1:       region = TIMER_REGION;
            default: region = 8'(take_bits(st, 8));
        endcase
        offset = 24'(take_bits(st, 24));
        return {region, offset};
    endfunction

    // ========================================
    // compare tasks
    // ========================================
    task automatic check_wr(input string name, input wr_req_t exp, input wr_req_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            wr_errs++;
        end
    endtask

    task automatic check_rd(input string name, input rd_req_t exp, input rd_req_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            rd_errs++;
        end
    endtask

    task automatic check_b(input string name, input b_resp_t exp, input b_resp_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            wr_errs++;
        end
    endtask

    task automatic check_r(input string name, input r_resp_t exp, input r_resp_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            rd_errs++;
        end
    endtask

    // ========================================
    // slave models
    // ========================================
    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slv
        tb_slave_model #(
            .req_t(wr_req_t), .resp_t(b_resp_t), .SIG(signature(i)),
            .RESP((i == DEFAULT_SLAVE) ? 2'b11 : 2'b00), .SEED(32'h729282a0 ^ (i + 1))
        ) u_wr_slv (
            .clk(clk), .rst_n(rst_n), .req_valid(aw_valid[i]), .req(aw_req[i]),
            .req_credit(aw_credit[i]), .resp_valid(bs_valid[i]), .resp(bs_resp[i]),
            .resp_credit(bs_credit[i]), .errors(wr_slv_err[i])
        );
        tb_slave_model #(
            .req_t(rd_req_t), .resp_t(r_resp_t), .SIG(signature(i)),
            .RESP((i == DEFAULT_SLAVE) ? 2'b11 : 2'b00), .SEED(32'h729282a0 ^ (i + 5))
        ) u_rd_slv (
            .clk(clk), .rst_n(rst_n), .req_valid(ar_valid[i]), .req(ar_req[i]),
            .req_credit(ar_credit[i]), .resp_valid(rs_valid[i]), .resp(rs_resp[i]),
            .resp_credit(rs_credit[i]), .errors(rd_slv_err[i])
        );
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================
    // master drivers
    // ========================================
    task automatic drive_writes();
        wr_req_t req;
        for (int n = 0; n < NUM_WR; n++) begin
            @(negedge clk);
            if (take_bits(wr_st, 2) == 0) begin
                wr_valid <= 1'b0;
                @(negedge clk);
            end
            req.addr = make_addr(wr_st);
            req.data = {take_bits(wr_st, 32), take_bits(wr_st, 32)};
            req.strb = STRB_W'(take_bits(wr_st, STRB_W));
            req.id   = ID_W'(take_bits(wr_st, ID_W));
            wr_valid <= 1'b1;
            wr_req   <= req;
            @(posedge clk);
            while (!wr_ready) @(posedge clk);
            exp_aw[route(req.addr)].push_back(req);
            exp_b.push_back(expected_write(req));
        end
        @(negedge clk);
        wr_valid <= 1'b0;
    endtask

    task automatic drive_reads();
        rd_req_t req;
        for (int n = 0; n < NUM_RD; n++) begin
            @(negedge clk);
            if (take_bits(rd_st, 2) == 0) begin
                rd_valid <= 1'b0;
                @(negedge clk);
            end
            req.addr = make_addr(rd_st);
            req.id   = ID_W'(take_bits(rd_st, ID_W));
            rd_valid <= 1'b1;
            rd_req   <= req;
            @(posedge clk);
            while (!rd_ready) @(posedge clk);
            exp_ar[route(req.addr)].push_back(req);
            exp_r.push_back(expected_read(req));
        end
        @(negedge clk);
        rd_valid <= 1'b0;
    endtask

    // random master back-pressure
    always @(negedge clk) begin
        if (rst_n) begin
            b_ready <= (take_bits(rdy_st, 2) != 0);
            r_ready <= (take_bits(rdy_st, 2) != 0);
        end
    end

    // ========================================
    // compare process
    // ========================================
    always @(posedge clk) begin
        if (!rst_n || post_rst) begin
            if (aw_valid != '0 || ar_valid != '0 || b_valid || r_valid ||
                bs_credit != '0 || rs_credit != '0) begin
                $display("a valid or credit output was high during or right after reset");
                other_errs++;
            end
            if (!rst_n && (wr_ready || rd_ready)) begin
                $display("master ready was high during reset");
                other_errs++;
            end
        end
        post_rst <= !rst_n;
        if (rst_n) begin
            for (int i = 0; i < NUM_SLAVES; i++) begin
                if (aw_valid[i] && exp_aw[i].size() == 0) begin
                    $display("slave %0d got a write that was never sent to it", i);
                    other_errs++;
                end else if (aw_valid[i]) begin
                    check_wr("write request", exp_aw[i].pop_front(), aw_req[i]);
                end
                if (ar_valid[i] && exp_ar[i].size() == 0) begin
                    $display("slave %0d got a read that was never sent to it", i);
                    other_errs++;
                end else if (ar_valid[i]) begin
                    check_rd("read request", exp_ar[i].pop_front(), ar_req[i]);
                end
            end
            if (b_valid && b_ready && exp_b.size() == 0) begin
                $display("write response without an outstanding write");
                other_errs++;
            end else if (b_valid && b_ready) begin
                check_b("write response", exp_b.pop_front(), b_resp);
            end
            if (r_valid && r_ready && exp_r.size() == 0) begin
                $display("read response without an outstanding read");
                other_errs++;
            end else if (r_valid && r_ready) begin
                check_r("read response", exp_r.pop_front(), r_resp);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles with responses still outstanding", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // ========================================
    // main sequence
    // ========================================
    initial begin
        int slv_errs;
        rst_n      = 1'b0;
        wr_valid   = 1'b0;
        wr_req     = '0;
        b_ready    = 1'b0;
        rd_valid   = 1'b0;
        rd_req     = '0;
        r_ready    = 1'b0;
        wr_errs    = 0;
        rd_errs    = 0;
        other_errs = 0;
        cycles     = 0;
        post_rst   = 1'b0;
        wr_st      = 32'h729282a0;
        rd_st      = 32'h729282a0 ^ 32'h0000_ffff;
        rdy_st     = 32'h729282a0 ^ 32'hffff_0000;
        repeat (10) @(negedge clk);
        rst_n <= 1'b1;
        fork
            drive_writes();
            drive_reads();
        join
        while (exp_b.size() != 0 || exp_r.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        slv_errs = 0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            slv_errs += wr_slv_err[i] + rd_slv_err[i];
            if (exp_aw[i].size() != 0 || exp_ar[i].size() != 0) begin
                $display("slave %0d never received some of its requests", i);
                other_errs++;
            end
        end
        $display("errors: write %0d read %0d slave %0d other %0d",
                 wr_errs, rd_errs, slv_errs, other_errs);
        if (wr_errs + rd_errs + slv_errs + other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tb_slave_model.sv */
// behavioral slave for the AXI router testbench
// queues requests against the credits it grants, answers them in
// order after random delays while it holds a response credit
`default_nettype none

module tb_slave_model #(
    parameter type req_t  = axi_router_types_pkg::rd_req_t,
    parameter type resp_t = axi_router_types_pkg::r_resp_t,
    parameter logic [63:0] SIG  = 64'h0,
    parameter logic [1:0]  RESP = 2'b00,
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  req_valid,
    input  req_t  req,
    output logic  req_credit,
    output logic  resp_valid,
    output resp_t resp,
    input  logic  resp_credit,
    output int    errors
);

    import axi_router_cfg_pkg::*;

    localparam int RESP_BITS = $bits(resp_t);

    req_t                 pending [$];
    req_t                 head;
    int                   credits;
    int                   delay;
    logic [31:0]          st;
    logic [ID_W-1:0]      id;
    logic [DATA_W-1:0]    data;
    logic [RESP_BITS-1:0] resp_bits;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin
        errors     = 0;
        st         = SEED;
        req_credit = 1'b0;
        resp_valid = 1'b0;
        resp       = '0;
    end

    // everything on the falling edge, DUT outputs are stable there
    always @(negedge clk) begin
        if (!rst_n) begin
            pending.delete();
            credits    = RESP_DEPTH;
            delay      = 0;
            req_credit <= 1'b0;
            resp_valid <= 1'b0;
            resp       <= '0;
        end else begin
            req_credit <= 1'b0;
            resp_valid <= 1'b0;
            if (resp_credit) begin
                credits = credits + 1;
                if (credits > RESP_DEPTH) begin
                    $display("slave model %m got more response credits than it gave out");
                    errors <= errors + 1;
                end
            end
            if (req_valid) begin
                if (pending.size() >= REQ_CREDITS) begin
                    $display("slave model %m got a request while its queue was full");
                    errors <= errors + 1;
                end
                pending.push_back(req);
            end
            if (delay > 0) begin
                delay = delay - 1;
            end else if (pending.size() > 0 && credits > 0) begin
                head = pending.pop_front();
                id   = head[ID_W-1:0];
                data = (RESP == 2'b11) ? '0 :
                       ({32'h0, head[$bits(req_t)-1 -: ADDR_W]} ^ SIG);
                // read responses carry data, write responses only id and resp
                resp_bits = (RESP_BITS > ID_W + RESP_W) ? {id, data, RESP} : {id, RESP};
                resp       <= resp_bits;
                resp_valid <= 1'b1;
                req_credit <= 1'b1;
                credits = credits - 1;
                st    = lfsr_next(st);
                st    = lfsr_next(st);
                delay = int'(st[1:0]);
            end
        end
    end

endmodule

`default_nettype wire
